// ==== design/ntm_dot_accumulator.sv ====
module ntm_dot_accumulator import ntm_pkg::*; (
  input  logic       CLK,
  input  logic       RST,

  // From the controller
  input  logic       acc_start,
  input  ntm_count_t term_count,

  // Head of the operand buffer
  input  logic       not_empty,
  input  ntm_data_t  head_a,
  input  ntm_data_t  head_b,
  output logic       pop,

  // Partial result towards summation
  output logic       result_valid,
  output ntm_data_t  result,
  input  logic       result_take
);

  //////////////////////////////////////////////////
  // Internal state
  //////////////////////////////////////////////////

  // Terms still to add, nonzero means busy
  ntm_count_t remaining;
  ntm_data_t  sum;
  ntm_data_t  product;
  logic       busy;

  assign busy = (remaining != '0);

  // Only the low word of the product is kept
  assign product = head_a * head_b;

  // One pair per cycle while terms remain
  assign pop = busy && not_empty;

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      remaining    <= '0;
      result_valid <= 1'b0;
    end else begin
      if (acc_start) begin
        remaining <= term_count;
      end else if (pop) begin
        remaining <= remaining - 1'b1;
        // Last term added, result is ready next cycle
        if (remaining == ntm_count_t'(1))
          result_valid <= 1'b1;
      end
      if (result_take)
        result_valid <= 1'b0;
    end
  end

  // Running sum, cleared per y
  always_ff @(posedge CLK) begin
    if (acc_start)
      sum <= '0;
    else if (pop)
      sum <= sum + product;
  end

  assign result = sum;

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Controller restarts only an idle, drained accumulator
  assert property (@(posedge CLK) disable iff (RST)
    acc_start |-> (!busy && !result_valid))
    else $error("accumulator started while busy or holding");

  assert property (@(posedge CLK) disable iff (RST)
    acc_start |-> (term_count != '0))
    else $error("accumulator started with zero terms");

endmodule

// ==== design/ntm_operand_fifo.sv ====
`include "ntm_params.svh"

module ntm_operand_fifo import ntm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,

  // Write side, from the source
  input  logic      push,
  input  ntm_data_t k_data,
  input  ntm_data_t r_data,

  // Read side, towards the accumulator
  input  logic      pop,
  output logic      not_empty,
  output ntm_data_t head_k,
  output ntm_data_t head_r,

  // One pulse per popped pair
  output logic      credit_out
);

  //////////////////////////////////////////////////
  // Storage and pointers
  //////////////////////////////////////////////////

  ntm_data_t mem_k [`NTM_FIFO_DEPTH];
  ntm_data_t mem_r [`NTM_FIFO_DEPTH];

  logic [`NTM_FIFO_AW-1:0] wr_ptr;
  logic [`NTM_FIFO_AW-1:0] rd_ptr;
  // One extra bit so a full buffer is distinct from empty
  logic [`NTM_FIFO_AW:0]   count;

  // Payload only, no reset
  always_ff @(posedge CLK) begin
    if (push) begin
      mem_k[wr_ptr] <= k_data;
      mem_r[wr_ptr] <= r_data;
    end
  end

  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credit_out <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      // Occupancy follows push and pop together
      if (push && !pop)
        count <= count + 1'b1;
      else if (!push && pop)
        count <= count - 1'b1;
      // Credit goes back one cycle after the pop
      credit_out <= pop;
    end
  end

  assign not_empty = (count != '0);
  assign head_k    = mem_k[rd_ptr];
  assign head_r    = mem_r[rd_ptr];

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Source pushed without holding a credit
  assert property (@(posedge CLK) disable iff (RST)
    push |-> (count != (`NTM_FIFO_AW+1)'(`NTM_FIFO_DEPTH)))
    else $error("operand fifo push while full");

  // Accumulator must only pop a present pair
  assert property (@(posedge CLK) disable iff (RST)
    pop |-> not_empty)
    else $error("operand fifo pop while empty");

endmodule

// ==== design/ntm_output_vector.sv ====
module ntm_output_vector import ntm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,

  // Control
  input  logic      start,
  input  ntm_size_t size_y,
  input  ntm_size_t size_l,
  input  ntm_size_t size_w,
  input  ntm_size_t size_r,
  output logic      ready,

  // K*r operand stream
  input  logic      kr_valid,
  input  ntm_data_t k_in,
  input  ntm_data_t r_in,
  output logic      kr_credit,

  // U*h operand stream
  input  logic      uh_valid,
  input  ntm_data_t u_in,
  input  ntm_data_t h_in,
  output logic      uh_credit,

  // y output stream
  output logic      y_valid,
  output ntm_data_t y_out,
  input  logic      y_credit
);

  //////////////////////////////////////////////////
  // Signals
  //////////////////////////////////////////////////

  ntm_ctrl_state_t state;
  logic            start_accept;
  logic            acc_start;
  logic            result_take;

  // Sizes of the current run
  ntm_size_t       size_y_q;
  ntm_size_t       size_l_q;
  ntm_count_t      term_kr;

  // y elements started and y elements sent
  ntm_size_t       y_issued;
  ntm_size_t       y_sent;
  logic            last_issued;
  logic            last_sent;

  // K*r path
  logic            kr_not_empty;
  ntm_data_t       kr_head_k;
  ntm_data_t       kr_head_r;
  logic            kr_pop;
  logic            kr_result_valid;
  ntm_data_t       kr_result;

  // U*h path
  logic            uh_not_empty;
  ntm_data_t       uh_head_u;
  ntm_data_t       uh_head_h;
  logic            uh_pop;
  logic            uh_result_valid;
  ntm_data_t       uh_result;

  //////////////////////////////////////////////////
  // Controller
  //////////////////////////////////////////////////

  // start only counts while idle
  assign start_accept = (state == ctrl_starter) && start;
  assign acc_start    = (state == ctrl_issue);
  assign last_issued  = (y_issued == size_y_q);
  assign last_sent    = (y_sent == size_y_q - 1'b1);

  // Sizes and W*R held for the whole run
  always_ff @(posedge CLK) begin
    if (start_accept) begin
      size_y_q <= size_y;
      size_l_q <= size_l;
      term_kr  <= ntm_count_t'(size_w) * ntm_count_t'(size_r);
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= ctrl_starter;
      y_issued <= '0;
      y_sent   <= '0;
      ready    <= 1'b0;
    end else begin
      ready <= 1'b0;
      // Every y pulse of the run is counted
      if (y_valid)
        y_sent <= y_sent + 1'b1;
      case (state)
        ctrl_starter: begin
          if (start) begin
            y_issued <= '0;
            y_sent   <= '0;
            state    <= ctrl_issue;
          end
        end
        // Both accumulators start on the next y
        ctrl_issue: begin
          y_issued <= y_issued + 1'b1;
          state    <= ctrl_wait;
        end
        // Free again once summation took both partials
        ctrl_wait: begin
          if (result_take)
            state <= last_issued ? ctrl_finish : ctrl_issue;
        end
        // Drain the remaining y elements
        ctrl_finish: begin
          if (y_valid && last_sent) begin
            ready <= 1'b1;
            state <= ctrl_starter;
          end
        end
        default: state <= ctrl_starter;
      endcase
    end
  end

  // Host must never start a run with an empty dimension
  assert property (@(posedge CLK) disable iff (RST)
    start_accept |-> (size_y != '0 && size_l != '0 && size_w != '0 && size_r != '0))
    else $error("start accepted with a zero size");

  //////////////////////////////////////////////////
  // Datapath instances
  //////////////////////////////////////////////////

  ntm_operand_fifo kr_fifo (
    .CLK        (CLK),
    .RST        (RST),
    .push       (kr_valid),
    .k_data     (k_in),
    .r_data     (r_in),
    .pop        (kr_pop),
    .not_empty  (kr_not_empty),
    .head_k     (kr_head_k),
    .head_r     (kr_head_r),
    .credit_out (kr_credit)
  );

  ntm_operand_fifo uh_fifo (
    .CLK        (CLK),
    .RST        (RST),
    .push       (uh_valid),
    .k_data     (u_in),
    .r_data     (h_in),
    .pop        (uh_pop),
    .not_empty  (uh_not_empty),
    .head_k     (uh_head_u),
    .head_r     (uh_head_h),
    .credit_out (uh_credit)
  );

  // W*R terms per y
  ntm_dot_accumulator kr_accumulator (
    .CLK          (CLK),
    .RST          (RST),
    .acc_start    (acc_start),
    .term_count   (term_kr),
    .not_empty    (kr_not_empty),
    .head_a       (kr_head_k),
    .head_b       (kr_head_r),
    .pop          (kr_pop),
    .result_valid (kr_result_valid),
    .result       (kr_result),
    .result_take  (result_take)
  );

  // L terms per y
  ntm_dot_accumulator uh_accumulator (
    .CLK          (CLK),
    .RST          (RST),
    .acc_start    (acc_start),
    .term_count   (ntm_count_t'(size_l_q)),
    .not_empty    (uh_not_empty),
    .head_a       (uh_head_u),
    .head_b       (uh_head_h),
    .pop          (uh_pop),
    .result_valid (uh_result_valid),
    .result       (uh_result),
    .result_take  (result_take)
  );

  ntm_vector_summation vector_summation (
    .CLK         (CLK),
    .RST         (RST),
    .a_valid     (kr_result_valid),
    .a_result    (kr_result),
    .b_valid     (uh_result_valid),
    .b_result    (uh_result),
    .result_take (result_take),
    .y_credit    (y_credit),
    .y_valid     (y_valid),
    .y_out       (y_out)
  );

endmodule

// ==== design/ntm_pkg.sv ====
`include "ntm_params.svh"

package ntm_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  // Operands, products and y elements
  typedef logic [`NTM_DATA_W-1:0] ntm_data_t;

  // Y, L, W and R sizes
  typedef logic [`NTM_SIZE_W-1:0] ntm_size_t;

  // Term counts such as W*R, twice the size width
  typedef logic [2*`NTM_SIZE_W-1:0] ntm_count_t;

  // Output credit counter
  typedef logic [`NTM_CREDIT_W-1:0] ntm_credit_t;

  //////////////////////////////////////////////////
  // Controller FSM
  //////////////////////////////////////////////////

  typedef enum logic [1:0] {
    ctrl_starter,
    ctrl_issue,
    ctrl_wait,
    ctrl_finish
  } ntm_ctrl_state_t;

endpackage

// ==== design/ntm_vector_summation.sv ====
`include "ntm_params.svh"

module ntm_vector_summation import ntm_pkg::*; (
  input  logic      CLK,
  input  logic      RST,

  // K*r partial result
  input  logic      a_valid,
  input  ntm_data_t a_result,

  // U*h partial result
  input  logic      b_valid,
  input  ntm_data_t b_result,

  // Shared take, both accumulators in one cycle
  output logic      result_take,

  // Output stream with credits
  input  logic      y_credit,
  output logic      y_valid,
  output ntm_data_t y_out
);

  //////////////////////////////////////////////////
  // Holding register
  //////////////////////////////////////////////////

  logic        hold_valid;
  ntm_data_t   hold_data;
  ntm_credit_t credits;
  logic        have_credit;

  // Both partials present and room to store the sum
  assign result_take = a_valid && b_valid && !hold_valid;

  // Send only while a credit is held
  assign have_credit = (credits != '0);
  assign y_valid     = hold_valid && have_credit;
  assign y_out       = hold_data;

  // Wrapped sum, payload only
  always_ff @(posedge CLK) begin
    if (result_take)
      hold_data <= a_result + b_result;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      hold_valid <= 1'b0;
    end else begin
      if (result_take)
        hold_valid <= 1'b1;
      else if (y_valid)
        hold_valid <= 1'b0;
    end
  end

  //////////////////////////////////////////////////
  // Output credits
  //////////////////////////////////////////////////

  // Up on a returned credit, down on each y sent
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits <= ntm_credit_t'(`NTM_Y_CREDITS);
    end else begin
      if (y_credit && !y_valid)
        credits <= credits + 1'b1;
      else if (!y_credit && y_valid)
        credits <= credits - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  // Sink returns no more credits than it was given
  assert property (@(posedge CLK) disable iff (RST)
    (y_credit && !y_valid) |-> (credits < ntm_credit_t'(`NTM_Y_CREDITS)))
    else $error("output credit counter above its initial count");

endmodule

// ==== include/ntm_params.svh ====
`ifndef NTM_PARAMS_SVH
`define NTM_PARAMS_SVH

//////////////////////////////////////////////////
// Datapath widths
//////////////////////////////////////////////////

// Operand, product and y word
`define NTM_DATA_W 32

// One size value (Y, L, W or R)
`define NTM_SIZE_W 8

//////////////////////////////////////////////////
// Buffering and credits
//////////////////////////////////////////////////

// Operand pairs per input buffer, also initial source credits
`define NTM_FIFO_DEPTH 4
`define NTM_FIFO_AW 2

// Output credits held after reset
`define NTM_Y_CREDITS 2
`define NTM_CREDIT_W 3

`endif

// ==== ntm_output_vector.f ====
+incdir+include
design/ntm_pkg.sv
design/ntm_operand_fifo.sv
design/ntm_dot_accumulator.sv
design/ntm_vector_summation.sv
design/ntm_output_vector.sv
sim/ntm_output_vector_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench and the DUT with Verilator, then run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f ntm_output_vector.f \
  --top-module ntm_output_vector_tb -o ntm_output_vector_sim || exit 1

# The run passes only if the pass line shows up in the output
out=$(./obj_dir/ntm_output_vector_sim 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "^TEST OK$" && exit 0 || exit 1

// ==== sim/ntm_output_vector_tb.sv ====
`include "ntm_params.svh"

module ntm_output_vector_tb import ntm_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  //////////////////////////////////////////////////
  // DUT signals
  //////////////////////////////////////////////////

  logic      CLK;
  logic      RST = 1'b1;
  logic      start = 1'b0;
  ntm_size_t size_y = '0;
  ntm_size_t size_l = '0;
  ntm_size_t size_w = '0;
  ntm_size_t size_r = '0;
  logic      ready;
  logic      kr_valid = 1'b0;
  ntm_data_t k_in = '0;
  ntm_data_t r_in = '0;
  logic      kr_credit;
  logic      uh_valid = 1'b0;
  ntm_data_t u_in = '0;
  ntm_data_t h_in = '0;
  logic      uh_credit;
  logic      y_valid;
  ntm_data_t y_out;
  logic      y_credit = 1'b0;

  // Operand pairs {a, b} in stream order, and model y values
  logic [63:0] kr_q[$];
  logic [63:0] uh_q[$];
  logic [31:0] exp_q[$];

  // Source side, sent pairs and credits seen coming back
  int kr_sent = 0;
  int uh_sent = 0;
  int kr_seen = 0;
  int uh_seen = 0;
  int kr_returned = 0;
  int uh_returned = 0;

  // Sink side
  int          y_got = 0;
  int          y_returned = 0;
  int          credit_wait = 0;
  logic        hold_credits = 1'b0;
  logic [31:0] sink_seed = 32'd13;
  // y_valid in the previous cycle
  logic        y_prev = 1'b0;

  // Run bookkeeping for the test tasks
  int          ready_count = 0;
  int          ready_base = 0;
  int          y_base = 0;
  int          budget = 100;
  logic [31:0] seed = 32'd13;

  ntm_output_vector ntm_output_vector_i (
    .CLK       (CLK),
    .RST       (RST),
    .start     (start),
    .size_y    (size_y),
    .size_l    (size_l),
    .size_w    (size_w),
    .size_r    (size_r),
    .ready     (ready),
    .kr_valid  (kr_valid),
    .k_in      (k_in),
    .r_in      (r_in),
    .kr_credit (kr_credit),
    .uh_valid  (uh_valid),
    .u_in      (u_in),
    .h_in      (h_in),
    .uh_credit (uh_credit),
    .y_valid   (y_valid),
    .y_out     (y_out),
    .y_credit  (y_credit)
  );

  initial begin
    CLK = 1'b0;
    forever #4 CLK = ~CLK;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string what);
    if (actual !== expected) begin
      $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
      $display("TEST FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  function automatic logic [31:0] lcg_step(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Reference model, one term: low word of the full product
  function automatic logic [31:0] mac_term(input logic [31:0] acc, input logic [31:0] a,
                                           input logic [31:0] b);
    logic [63:0] full;
    full = {32'd0, a} * {32'd0, b};
    return acc + full[31:0];
  endfunction

  // Mode 1 keeps operands just under 2^32
  task automatic next_operand(input int mode, output logic [31:0] v);
    seed = lcg_step(seed);
    if (mode == 1)
      v = 32'hFFFF_FFFF - {24'd0, seed[31:24]};
    else
      v = seed;
  endtask

  //////////////////////////////////////////////////
  // Source, sink and monitor
  //////////////////////////////////////////////////

  // At most NTM_FIFO_DEPTH pairs in flight per stream
  always @(posedge CLK) begin
    kr_valid <= 1'b0;
    uh_valid <= 1'b0;
    if (!RST && kr_sent < kr_q.size() && kr_sent - kr_returned < `NTM_FIFO_DEPTH) begin
      kr_valid <= 1'b1;
      k_in     <= kr_q[kr_sent][63:32];
      r_in     <= kr_q[kr_sent][31:0];
      kr_sent  = kr_sent + 1;
    end
    if (!RST && uh_sent < uh_q.size() && uh_sent - uh_returned < `NTM_FIFO_DEPTH) begin
      uh_valid <= 1'b1;
      u_in     <= uh_q[uh_sent][63:32];
      h_in     <= uh_q[uh_sent][31:0];
      uh_sent  = uh_sent + 1;
    end
  end

  // Credit back for each y taken, after a random delay
  always @(posedge CLK) begin
    y_credit <= 1'b0;
    if (!RST && !hold_credits && y_got > y_returned) begin
      if (credit_wait != 0) begin
        credit_wait = credit_wait - 1;
      end else begin
        y_credit    <= 1'b1;
        y_returned  = y_returned + 1;
        sink_seed   = lcg_step(sink_seed);
        credit_wait = int'(sink_seed[26:24]);
      end
    end
  end

  // Outputs sampled mid-cycle
  always @(negedge CLK) begin
    if (!RST) begin
      if (kr_valid)
        kr_seen = kr_seen + 1;
      if (uh_valid)
        uh_seen = uh_seen + 1;
      if (kr_credit)
        kr_returned = kr_returned + 1;
      if (uh_credit)
        uh_returned = uh_returned + 1;
      // No credit without a pair pushed before it
      check(32'(kr_returned <= kr_seen), 1, "kr_credit with no pair outstanding");
      check(32'(uh_returned <= uh_seen), 1, "uh_credit with no pair outstanding");
      if (y_valid) begin
        check(32'(y_got < exp_q.size()), 1, "y_valid with no y expected");
        check(y_out, exp_q[y_got], "y value against the model");
        y_got = y_got + 1;
        check(32'(y_got <= `NTM_Y_CREDITS + y_returned), 1, "y_valid beyond granted credits");
      end
      if (ready) begin
        ready_count = ready_count + 1;
        check(y_got, exp_q.size(), "ready before every y was sent");
        check(32'(y_prev), 1, "ready not in the cycle after the last y");
      end
      y_prev = y_valid;
    end
  end

  // Budget grows with every run that is loaded
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < budget) begin
      @(posedge CLK);
      cycles = cycles + 1;
    end
    $display("timeout: the DUT did not finish the tests within %0d cycles", budget);
    $display("TEST FAILED");
    $fatal(1, "watchdog expired");
  end

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  task automatic load_run(input int ny, input int nl, input int nw, input int nr,
                          input int mode);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] acc;
    @(negedge CLK);
    for (int yi = 0; yi < ny; yi++) begin
      acc = '0;
      for (int t = 0; t < nw * nr; t++) begin
        next_operand(mode, a);
        next_operand(mode, b);
        kr_q.push_back({a, b});
        acc = mac_term(acc, a, b);
      end
      for (int t = 0; t < nl; t++) begin
        next_operand(mode, a);
        next_operand(mode, b);
        uh_q.push_back({a, b});
        acc = mac_term(acc, a, b);
      end
      exp_q.push_back(acc);
    end
    budget = budget + 4 * ny * (nw * nr + nl) + 40 * ny + 50;
  endtask

  task automatic kick_run(input int ny, input int nl, input int nw, input int nr);
    @(posedge CLK);
    ready_base = ready_count;
    y_base     = y_got;
    start  <= 1'b1;
    size_y <= ntm_size_t'(ny);
    size_l <= ntm_size_t'(nl);
    size_w <= ntm_size_t'(nw);
    size_r <= ntm_size_t'(nr);
    @(posedge CLK);
    start  <= 1'b0;
  endtask

  // Wait for ready, then the run must be fully accounted for
  task automatic finish_run(input int ny);
    while (ready_count == ready_base)
      @(posedge CLK);
    // Ready must stay a single pulse
    repeat (4)
      @(negedge CLK);
    check(ready_count - ready_base, 1, "ready pulses in the run");
    check(y_got - y_base, ny, "y elements in the run");
    check(kr_sent, kr_q.size(), "kr pairs left unsent");
    check(uh_sent, uh_q.size(), "uh pairs left unsent");
    check(`NTM_FIFO_DEPTH - (kr_sent - kr_returned), `NTM_FIFO_DEPTH, "kr credits after run");
    check(`NTM_FIFO_DEPTH - (uh_sent - uh_returned), `NTM_FIFO_DEPTH, "uh credits after run");
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_reset_idle();
    @(negedge CLK);
    check(32'(ready), 0, "ready after reset");
    check(32'(y_valid), 0, "y_valid after reset");
    check(32'(kr_credit), 0, "kr_credit after reset");
    check(32'(uh_credit), 0, "uh_credit after reset");
    repeat (12) begin
      @(negedge CLK);
      check(32'(y_valid), 0, "y_valid before any start");
    end
    check(y_got, 0, "y count before any start");
  endtask

  task automatic test_single();
    @(negedge CLK);
    kr_q.push_back({32'd3, 32'd5});
    kr_q.push_back({32'd7, 32'd11});
    uh_q.push_back({32'd2, 32'd13});
    uh_q.push_back({32'd4, 32'd6});
    // 3*5 + 7*11 + 2*13 + 4*6
    exp_q.push_back(32'd142);
    budget = budget + 100;
    kick_run(1, 2, 2, 1);
    finish_run(1);
  endtask

  task automatic test_random(input int runs);
    int ny;
    int nl;
    int nw;
    int nr;
    repeat (runs) begin
      seed = lcg_step(seed);
      ny = 1 + int'(seed[31:30]);
      nl = 1 + int'(seed[29:28]);
      nw = 1 + int'(seed[27:26]);
      nr = 1 + int'(seed[25:24]);
      load_run(ny, nl, nw, nr, 0);
      kick_run(ny, nl, nw, nr);
      finish_run(ny);
    end
  endtask

  // Products and sums overflow 32 bits
  task automatic test_wrap();
    load_run(3, 4, 4, 4, 1);
    kick_run(3, 4, 4, 4);
    finish_run(3);
  endtask

  task automatic test_back_pressure();
    load_run(4, 2, 2, 2, 0);
    budget = budget + 3 * 70;
    hold_credits <= 1'b1;
    kick_run(4, 2, 2, 2);
    repeat (60)
      @(negedge CLK);
    // Every held credit spent, nothing more went out
    check(y_got, `NTM_Y_CREDITS + y_returned, "y count while credits are held back");
    repeat (2) begin
      hold_credits <= 1'b0;
      repeat (5)
        @(negedge CLK);
      hold_credits <= 1'b1;
      repeat (60)
        @(negedge CLK);
    end
    hold_credits <= 1'b0;
    finish_run(4);
  endtask

  //////////////////////////////////////////////////
  // Sequence
  //////////////////////////////////////////////////

  initial begin : main
    repeat (2)
      @(posedge CLK);
    RST <= 1'b0;
    test_reset_idle();
    test_single();
    test_random(6);
    test_wrap();
    test_back_pressure();
    test_random(2);
    $display("TEST OK");
    $finish;
  end

endmodule
